// ==== rom_check_top.f ====
+incdir+rtl
rtl/rom_hash_pkg.sv
rtl/rom_check_pkg.sv
rtl/rom_addr_counter.sv
rtl/rom_digest_engine.sv
rtl/rom_digest_compare.sv
rtl/rom_check_fsm.sv
rtl/rom_check_top.sv
test/tb_rom_check.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ROM check testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f rom_check_top.f \
  --top-module tb_rom_check -Mdir obj_dir -o sim_rom_check
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_rom_check > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL, pass line missing from $LOG"
  exit 1
fi

// ==== test/tb_rom_check.sv ====
// ####################
// ROM integrity checker testbench
// Models the ROM, predicts the digest and runs directed checks
// ####################

`timescale 1ns/1ps

`include "rom_check_macros.svh"

module tb_rom_check
  import rom_check_pkg::*;
  import rom_hash_pkg::*;
();

  localparam int Depth    = `ROM_DEPTH;
  localparam int Dw       = `DIGEST_WORDS;
  localparam int LowWords = Depth - Dw;
  localparam int Aw       = `ROM_AW;
  localparam int CmpW     = 32 * Dw;
  // One full walk plus finalization, compare and a generous margin
  localparam int RunCycles  = 2 * Depth + 8 * Dw + 20;
  localparam int PostCycles = 20;
  localparam int NumRand    = 5;
  // Good image, bit flip, one run per expected word, address walk, random images
  localparam int NumRuns    = 3 + Dw + NumRand;
  localparam int WatchdogNs = NumRuns * (RunCycles + PostCycles + 8) * 10;

  logic               clk_i;
  logic               rst_ni;
  logic [31:0]        rom_data_i;
  logic               rom_req_o;
  logic [Aw-1:0]      rom_addr_o;
  logic               rom_select_o;
  check_status_t      check_status_o;
  digest_t            digest_o;
  logic               alert_o;

  // ROM contents and the request seen on the previous cycle
  logic [31:0]   rom [Depth];
  logic          pend_req;
  logic [Aw-1:0] pend_addr;
  logic [Aw-1:0] req_log [$];

  rom_check_top UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rom_data_i     (rom_data_i),
    .rom_req_o      (rom_req_o),
    .rom_addr_o     (rom_addr_o),
    .rom_select_o   (rom_select_o),
    .check_status_o (check_status_o),
    .digest_o       (digest_o),
    .alert_o        (alert_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_equal(input string name, input logic [CmpW-1:0] got,
                             input logic [CmpW-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got=%0h exp=%0h", $time, name, got, exp));
    end
  endtask

  // The ROM answers a request one cycle later, the word is driven at the next falling edge
  // The same edge logs requests and watches select and alert while the walk runs
  always @(negedge clk_i) begin
    if (pend_req) begin
      rom_data_i <= rom[pend_addr];
    end else begin
      rom_data_i <= '0;
    end
    pend_req  = rom_req_o;
    pend_addr = rom_addr_o;
    if (rom_req_o) begin
      req_log.push_back(rom_addr_o);
    end
    if (rst_ni) begin
      check_equal("alert_o", alert_o, 1'b0);
      if (!check_status_o.done) begin
        check_equal("rom_select_o", rom_select_o, 1'b1);
      end
    end
  end

  function automatic logic [31:0] rotate_left(input logic [31:0] x, input int n);
    return (x << n) | (x >> (32 - n));
  endfunction

  // Expected digest of the code image now in the ROM
  task automatic model_digest(output digest_t dig);
    logic [31:0] lanes [Dw];
    int          lane;
    for (int r = 0; r < Dw; r++) begin
      lanes[r] = `HASH_IV ^ 32'(r);
    end
    // Beat k updates lane k mod Dw
    for (int k = 0; k < LowWords; k++) begin
      lane = k % Dw;
      lanes[lane] = rotate_left(lanes[lane], `HASH_ROT_ABSORB) ^ (rom[k] + 32'(k));
    end
    // Each fold step sees the lanes already rewritten
    for (int r = 0; r < Dw; r++) begin
      lanes[r] = lanes[r] ^ rotate_left(lanes[(r + 1) % Dw], `HASH_ROT_FINAL);
    end
    for (int r = 0; r < Dw; r++) begin
      dig[r] = lanes[r];
    end
  endtask

  task automatic fill_pattern();
    for (int i = 0; i < LowWords; i++) begin
      rom[i] = 32'h1357_9bdf ^ (32'(i) * 32'h9e37_79b9);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < LowWords; i++) begin
      rom[i] = $urandom;
    end
  endtask

  task automatic store_digest(input digest_t dig);
    for (int i = 0; i < Dw; i++) begin
      rom[LowWords + i] = dig[i];
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    req_log.delete();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!check_status_o.done && cycles < RunCycles) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!check_status_o.done) begin
      abort_run($sformatf("check_status_o.done did not rise within %0d cycles", RunCycles));
    end
  endtask

  task automatic check_outcome(input logic good_exp, input digest_t dig_exp);
    check_equal("check_status_o.done", check_status_o.done, 1'b1);
    check_equal("check_status_o.good", check_status_o.good, good_exp);
    check_equal("digest_o", digest_o, dig_exp);
    check_equal("rom_select_o", rom_select_o, 1'b0);
    check_equal("alert_o", alert_o, 1'b0);
  endtask

  task automatic good_image_passes();
    digest_t dig;
    fill_pattern();
    model_digest(dig);
    store_digest(dig);
    apply_reset();
    wait_done();
    check_outcome(1'b1, dig);
  endtask

  // The stored digest belongs to the unmodified image
  task automatic flipped_code_bit_fails();
    digest_t dig;
    fill_pattern();
    model_digest(dig);
    store_digest(dig);
    rom[LowWords / 2] = rom[LowWords / 2] ^ 32'h0000_2000;
    model_digest(dig);
    apply_reset();
    wait_done();
    check_outcome(1'b0, dig);
  endtask

  task automatic corrupt_expected_fails();
    digest_t dig;
    for (int idx = 0; idx < Dw; idx++) begin
      fill_pattern();
      model_digest(dig);
      store_digest(dig);
      rom[LowWords + idx] = rom[LowWords + idx] ^ (32'h1 << (idx * 5));
      apply_reset();
      wait_done();
      check_outcome(1'b0, dig);
    end
  endtask

  // Requests must climb from 0 to the top, a stalled address may repeat
  task automatic address_walk_in_order();
    digest_t dig;
    int      n;
    fill_pattern();
    model_digest(dig);
    store_digest(dig);
    apply_reset();
    wait_done();
    check_outcome(1'b1, dig);
    n = req_log.size();
    if (n < Depth) begin
      abort_run($sformatf("only %0d ROM requests were seen for %0d words", n, Depth));
    end
    check_equal("first rom_addr_o", req_log[0], '0);
    for (int i = 1; i < n; i++) begin
      if (int'(req_log[i]) != int'(req_log[i - 1]) &&
          int'(req_log[i]) != int'(req_log[i - 1]) + 1) begin
        abort_run($sformatf("ROM address %0d was requested right after %0d",
                            req_log[i], req_log[i - 1]));
      end
    end
    check_equal("last rom_addr_o", req_log[n - 1], Depth - 1);
  endtask

  task automatic random_images_pass();
    digest_t dig;
    for (int n = 0; n < NumRand; n++) begin
      fill_random();
      model_digest(dig);
      store_digest(dig);
      apply_reset();
      wait_done();
      check_outcome(1'b1, dig);
      // The ROM belongs to the system again and sees no more requests
      repeat (PostCycles) begin
        @(negedge clk_i);
        check_equal("rom_req_o", rom_req_o, 1'b0);
        check_equal("check_status_o.done", check_status_o.done, 1'b1);
      end
    end
  endtask

  initial begin
    #(WatchdogNs);
    abort_run($sformatf("watchdog expired after %0d ns", WatchdogNs));
  end

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    rom_data_i = '0;
    pend_req   = 1'b0;
    pend_addr  = '0;
    void'($urandom(32'h4f9a));
    for (int i = 0; i < Depth; i++) begin
      rom[i] = '0;
    end
    good_image_passes();
    flipped_code_bit_fails();
    corrupt_expected_fails();
    address_walk_in_order();
    random_images_pass();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== rtl/rom_check_top.sv ====
// ####################
// ROM integrity checker
// Hashes the ROM at boot and checks it against the stored digest
// ####################

`timescale 1ns/1ps

`include "rom_check_macros.svh"

module rom_check_top
  import rom_check_pkg::*;
  import rom_hash_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [31:0]        rom_data_i,
  output logic               rom_req_o,
  output logic [`ROM_AW-1:0] rom_addr_o,
  output logic               rom_select_o,
  output check_status_t      check_status_o,
  output digest_t            digest_o,
  output logic               alert_o
);

  localparam int IdxW = $clog2(`DIGEST_WORDS);

  // Counter to FSM
  logic               ctr_done;
  logic               ctr_last_low;
  logic               ctr_data_rdy;
  logic [`ROM_AW-1:0] ctr_data_addr;

  // FSM to engine
  logic       beat_vld;
  logic       beat_rdy;
  hash_beat_t beat;
  logic       hash_done;
  digest_t    digest;

  // FSM to compare
  logic            exp_vld;
  logic [IdxW-1:0] exp_idx;
  logic [31:0]     exp_word;
  logic            cmp_start;
  logic            cmp_done;
  logic            cmp_good;

  rom_addr_counter u_counter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_rdy_i      (ctr_data_rdy),
    .read_req_o      (rom_req_o),
    .read_addr_o     (rom_addr_o),
    .data_addr_o     (ctr_data_addr),
    .data_last_low_o (ctr_last_low),
    .done_o          (ctr_done)
  );

  rom_digest_engine u_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .beat_vld_i (beat_vld),
    .beat_i     (beat),
    .beat_rdy_o (beat_rdy),
    .done_o     (hash_done),
    .digest_o   (digest)
  );

  rom_digest_compare u_compare (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .exp_vld_i  (exp_vld),
    .exp_idx_i  (exp_idx),
    .exp_word_i (exp_word),
    .digest_i   (digest),
    .start_i    (cmp_start),
    .done_o     (cmp_done),
    .good_o     (cmp_good)
  );

  rom_check_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ctr_done_i      (ctr_done),
    .ctr_last_low_i  (ctr_last_low),
    .ctr_data_addr_i (ctr_data_addr),
    .ctr_data_rdy_o  (ctr_data_rdy),
    .rom_data_i      (rom_data_i),
    .beat_vld_o      (beat_vld),
    .beat_o          (beat),
    .beat_rdy_i      (beat_rdy),
    .hash_done_i     (hash_done),
    .exp_vld_o       (exp_vld),
    .exp_idx_o       (exp_idx),
    .exp_word_o      (exp_word),
    .cmp_start_o     (cmp_start),
    .cmp_done_i      (cmp_done),
    .cmp_good_i      (cmp_good),
    .status_o        (check_status_o),
    .rom_select_o    (rom_select_o),
    .alert_o         (alert_o)
  );

  // The computed digest stays visible after the check
  assign digest_o = digest;

endmodule

// ==== rtl/rom_check_fsm.sv ====
// ####################
// ROM check sequencer
// Drives hashing, digest capture and compare, and flags inconsistent done signals
// ####################

`timescale 1ns/1ps

`include "rom_check_macros.svh"

module rom_check_fsm
  import rom_check_pkg::*;
  import rom_hash_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             ctr_done_i,
  input  logic                             ctr_last_low_i,
  input  logic [`ROM_AW-1:0]               ctr_data_addr_i,
  output logic                             ctr_data_rdy_o,
  input  logic [31:0]                      rom_data_i,
  output logic                             beat_vld_o,
  output hash_beat_t                       beat_o,
  input  logic                             beat_rdy_i,
  input  logic                             hash_done_i,
  output logic                             exp_vld_o,
  output logic [$clog2(`DIGEST_WORDS)-1:0] exp_idx_o,
  output logic [31:0]                      exp_word_o,
  output logic                             cmp_start_o,
  input  logic                             cmp_done_i,
  input  logic                             cmp_good_i,
  output check_status_t                    status_o,
  output logic                             rom_select_o,
  output logic                             alert_o
);

  localparam int AW   = `ROM_AW;
  localparam int IdxW = $clog2(`DIGEST_WORDS);
  localparam logic [AW-1:0] TopStart = AW'(`ROM_DEPTH - `DIGEST_WORDS);

  fsm_state_e    state_d;
  fsm_state_e    state_q;
  logic          boot_q;
  logic          word_vld_q;
  logic          start_q;
  logic          in_done;
  logic          ctr_dropped;
  logic [AW-1:0] rel_addr;

  // The counter requests on every cycle from the first edge after reset until it is done
  // A word is therefore on the ROM bus from the second edge onwards
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_q     <= 1'b0;
      word_vld_q <= 1'b0;
    end else begin
      boot_q     <= 1'b1;
      word_vld_q <= boot_q;
    end
  end

  assign in_done = state_q == Done;

  // The counter must never fall back once the walk is complete
  assign ctr_dropped = in_done && !ctr_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ReadingLow: begin
        // Move on once the last code word has gone into the engine
        if (ctr_last_low_i && beat_vld_o && beat_rdy_i) begin
          state_d = ReadingHigh;
        end
      end
      ReadingHigh: begin
        // The ROM walk and the engine's finalization race each other
        case ({hash_done_i, ctr_done_i})
          2'b01:   state_d = RomAhead;
          2'b10:   state_d = HashAhead;
          2'b11:   state_d = Checking;
          default: state_d = ReadingHigh;
        endcase
      end
      RomAhead: begin
        if (hash_done_i) begin
          state_d = Checking;
        end
      end
      HashAhead: begin
        if (ctr_done_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (cmp_done_i) begin
          state_d = Done;
        end
      end
      Done: begin
        state_d = Done;
      end
      default: begin
        state_d = Invalid;
      end
    endcase

    // Done pulses are only legal in the states that wait for them
    if ((cmp_done_i && !(state_q inside {Checking, Done})) ||
        (ctr_done_i && state_q == ReadingLow) ||
        (hash_done_i && !(state_q inside {ReadingHigh, RomAhead}))) begin
      state_d = Invalid;
    end

    // Any alert locks the FSM up as well
    if (alert_o) begin
      state_d = Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReadingLow;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // One-cycle start as Checking is entered
      start_q <= (state_q != Checking) && (state_d == Checking);
    end
  end

  // Code words go straight from the ROM bus into the engine
  assign beat_vld_o = word_vld_q && (state_q == ReadingLow);
  assign beat_o     = '{data: rom_data_i, last: ctr_last_low_i};

  // Top words are never stalled, low words follow the engine's back-pressure
  assign ctr_data_rdy_o = (state_q == ReadingLow) ? beat_rdy_i :
                          (state_q inside {ReadingHigh, HashAhead});

  // Snoop the expected digest while the top of the ROM streams past
  assign rel_addr   = ctr_data_addr_i - TopStart;
  assign exp_vld_o  = (state_q inside {ReadingHigh, HashAhead}) && !ctr_done_i;
  assign exp_idx_o  = rel_addr[IdxW-1:0];
  assign exp_word_o = rom_data_i;

  assign cmp_start_o = start_q;

  assign status_o = '{done: in_done, good: in_done && cmp_good_i};

  // The checker owns the ROM from reset until it is done
  assign rom_select_o = !in_done;

  assign alert_o = (state_q == Invalid) || ctr_dropped;

endmodule

// ==== rtl/rom_digest_compare.sv ====
// ####################
// ROM digest compare
// Holds the expected digest and checks it one word per cycle
// ####################

`timescale 1ns/1ps

`include "rom_check_macros.svh"

module rom_digest_compare
  import rom_hash_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             exp_vld_i,
  input  logic [$clog2(`DIGEST_WORDS)-1:0] exp_idx_i,
  input  logic [31:0]                      exp_word_i,
  input  digest_t                          digest_i,
  input  logic                             start_i,
  output logic                             done_o,
  output logic                             good_o
);

  localparam int IdxW = $clog2(`DIGEST_WORDS);
  localparam logic [IdxW-1:0] LastIdx = IdxW'(`DIGEST_WORDS - 1);

  digest_t         exp_q;
  logic            busy_q;
  logic            done_q;
  logic            good_q;
  logic [IdxW-1:0] idx_q;
  logic            active;
  logic [IdxW-1:0] cmp_idx;
  logic            mismatch;

  // Expected words are captured as the FSM snoops them off the ROM bus
  always_ff @(posedge clk_i) begin
    if (exp_vld_i) begin
      exp_q[exp_idx_i] <= exp_word_i;
    end
  end

  // Word 0 is checked in the start cycle itself
  assign active   = start_i || busy_q;
  assign cmp_idx  = start_i ? '0 : idx_q;
  assign mismatch = exp_q[cmp_idx] != digest_i[cmp_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      good_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      done_q <= active && (cmp_idx == LastIdx);
      if (active) begin
        busy_q <= cmp_idx != LastIdx;
        idx_q  <= cmp_idx + IdxW'(1);
        // A single mismatching word makes the whole result bad
        good_q <= (start_i || good_q) && !mismatch;
      end
    end
  end

  assign done_o = done_q;
  assign good_o = good_q;

endmodule

// ==== rtl/rom_digest_engine.sv ====
// ####################
// ROM digest engine
// Absorbs code words into lanes, then folds the lanes into a digest
// ####################

`timescale 1ns/1ps

`include "rom_check_macros.svh"

module rom_digest_engine
  import rom_hash_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       beat_vld_i,
  input  hash_beat_t beat_i,
  output logic       beat_rdy_o,
  output logic       done_o,
  output digest_t    digest_o
);

  localparam int LaneW = $clog2(`DIGEST_WORDS);
  localparam logic [LaneW-1:0] LastLane = LaneW'(`DIGEST_WORDS - 1);

  function automatic logic [31:0] rotl(input logic [31:0] x, input int unsigned n);
    rotl = (x << n) | (x >> (32 - n));
  endfunction

  digest_t               lanes_q;
  logic [`ROM_AW-1:0]    beat_cnt_q;
  logic                  fin_q;
  logic                  sealed_q;
  logic                  done_q;
  logic [LaneW-1:0]      fin_idx_q;
  logic                  beat_fire;
  logic [LaneW-1:0]      abs_lane;
  logic [LaneW-1:0]      nxt_lane;
  logic [31:0]           abs_word;
  logic [31:0]           fin_word;

  // Only ready while absorbing, the engine is used once per reset
  assign beat_rdy_o = !fin_q && !sealed_q;
  assign beat_fire  = beat_vld_i && beat_rdy_o;

  // Beat k lands in lane k mod DIGEST_WORDS, the low bits do that for a power of two
  assign abs_lane = beat_cnt_q[LaneW-1:0];
  assign abs_word = rotl(lanes_q[abs_lane], `HASH_ROT_ABSORB) ^
                    (beat_i.data + 32'(beat_cnt_q));

  // Finalization mixes in the next lane, wrapping back to lane 0
  // Lane 0 has already been rewritten by the time the last lane reads it
  assign nxt_lane = fin_idx_q + LaneW'(1);
  assign fin_word = lanes_q[fin_idx_q] ^ rotl(lanes_q[nxt_lane], `HASH_ROT_FINAL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `DIGEST_WORDS; i++) begin
        lanes_q[i] <= `HASH_IV ^ 32'(i);
      end
      beat_cnt_q <= '0;
      fin_q      <= 1'b0;
      sealed_q   <= 1'b0;
      fin_idx_q  <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (beat_fire) begin
        lanes_q[abs_lane] <= abs_word;
        beat_cnt_q        <= beat_cnt_q + 1'b1;
        // The last code word starts the fold
        if (beat_i.last) begin
          fin_q     <= 1'b1;
          fin_idx_q <= '0;
        end
      end
      // One lane per cycle during finalization
      if (fin_q) begin
        lanes_q[fin_idx_q] <= fin_word;
        fin_idx_q          <= nxt_lane;
        if (fin_idx_q == LastLane) begin
          fin_q    <= 1'b0;
          sealed_q <= 1'b1;
          done_q   <= 1'b1;
        end
      end
    end
  end

  assign done_o = done_q;

  // Lanes are frozen once sealed, so the digest stays stable
  assign digest_o = lanes_q;

endmodule

// ==== rtl/rom_addr_counter.sv ====
// ####################
// ROM address counter
// Walks every ROM address once, stalling on back-pressure
// ####################

`timescale 1ns/1ps

`include "rom_check_macros.svh"

module rom_addr_counter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                data_rdy_i,
  output logic                read_req_o,
  output logic [`ROM_AW-1:0]  read_addr_o,
  output logic [`ROM_AW-1:0]  data_addr_o,
  output logic                data_last_low_o,
  output logic                done_o
);

  localparam int AW = `ROM_AW;
  localparam logic [AW-1:0] LastAddr    = AW'(`ROM_DEPTH - 1);
  localparam logic [AW-1:0] LastLowAddr = AW'(`ROM_DEPTH - `DIGEST_WORDS - 1);

  // Addr_q is the address whose word is on the ROM data bus when vld_q is set
  // Before the first word comes back it is the first address to request
  logic          req_q;
  logic          vld_q;
  logic          done_q;
  logic [AW-1:0] addr_q;
  logic          go;
  logic          go_last;

  // The word on the bus is taken this cycle
  assign go      = vld_q && data_rdy_i;
  assign go_last = go && (addr_q == LastAddr);

  // A taken word lets us move on, otherwise the same address is asked for again
  // Nothing new is requested once the final word has been taken
  assign read_req_o  = req_q && !go_last;
  assign read_addr_o = go ? addr_q + AW'(1) : addr_q;

  assign data_addr_o     = addr_q;
  assign data_last_low_o = vld_q && (addr_q == LastLowAddr);
  assign done_o          = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      vld_q  <= 1'b0;
      done_q <= 1'b0;
      addr_q <= '0;
    end else begin
      // The ROM answers every request exactly one cycle later
      vld_q <= read_req_o;
      req_q <= !done_q && !go_last;
      if (go && !go_last) begin
        addr_q <= read_addr_o;
      end
      // Sticky until the next reset
      if (go_last) begin
        done_q <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/rom_check_pkg.sv ====
// ####################
// ROM check control package
// FSM states and the status reported to the system
// ####################

package rom_check_pkg;

  // Sequencer states
  // ReadingLow feeds the code image into the digest engine
  // ReadingHigh captures the expected digest while the engine finalizes
  // RomAhead means the ROM walk is over but the engine is still busy
  // HashAhead means the engine is done but top words are still being read
  // Checking runs the word-by-word digest comparison
  // Done is terminal and hands the ROM back to the system
  // Invalid is terminal and reached only on an inconsistency
  typedef enum logic [2:0] {
    ReadingLow,
    ReadingHigh,
    RomAhead,
    HashAhead,
    Checking,
    Done,
    Invalid
  } fsm_state_e;

  // Boot status seen by the rest of the system
  // Good only carries meaning once done is set
  typedef struct packed {
    logic done;
    logic good;
  } check_status_t;

endpackage

// ==== rtl/rom_hash_pkg.sv ====
// ####################
// ROM hash package
// Digest layout and the beat fed into the engine
// ####################

`include "rom_check_macros.svh"

package rom_hash_pkg;

  // Computed or expected digest, word 0 sits in the low 32 bits
  typedef logic [`DIGEST_WORDS-1:0][31:0] digest_t;

  // One ROM word on its way into the digest engine
  // Last marks the final word of the code image
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } hash_beat_t;

endpackage

// ==== rtl/rom_check_macros.svh ====
// ####################
// ROM check sizing and hash constants
// Shared by the control and hash sides of the checker
// ####################

`ifndef ROM_CHECK_MACROS_SVH
`define ROM_CHECK_MACROS_SVH

// Number of 32-bit words in the external ROM
`define ROM_DEPTH 32

// Number of 32-bit digest words, stored in the top ROM addresses
`define DIGEST_WORDS 4

// Address width for the whole ROM
`define ROM_AW $clog2(`ROM_DEPTH)

// Mixing constants of the digest engine
`define HASH_IV 32'h6a09e667
`define HASH_ROT_ABSORB 7
`define HASH_ROT_FINAL 3

`endif
